// File: src/seq_pkg.sv
// Widths, opcodes and packed structs shared by the vector sequencer RTL
// Other files reference these by scoped name

package seq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Instructions that can be in flight at once
  localparam int unsigned NrVInsn = 8;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;
  // ALU, multiplier, load unit and store unit
  localparam int unsigned NrUnits = 4;

  // Instruction ID and one-hot set of IDs
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [NrVInsn-1:0]         vinsn_mask_t;

  // Vector register index
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // v0 holds the mask for masked instructions
  localparam vreg_t MaskReg = 5'd0;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_VADD  = 3'd0,
    OP_VSUB  = 3'd1,
    OP_VMUL  = 3'd2,
    OP_VMACC = 3'd3,
    OP_VLE   = 3'd4,
    OP_VSE   = 3'd5
  } seq_op_e;

  // Also the row index of the running table
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Dispatcher request, vm is active low
  typedef struct packed {
    seq_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    logic    vm;
  } seq_req_t;

  // Decode result
  typedef struct packed {
    unit_e unit;
    logic  use_vs1;
    logic  use_vs2;
    logic  reads_vd;
    logic  writes_vd;
  } decoded_t;

  // Request toward the functional units, with its dependencies
  typedef struct packed {
    vid_t        id;
    seq_op_e     op;
    unit_e       unit;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        vm;
    vinsn_mask_t hazard_vs1;
    vinsn_mask_t hazard_vs2;
    vinsn_mask_t hazard_vm;
    vinsn_mask_t hazard_vd;
  } pe_req_t;

endpackage

// File: src/seq_decode.sv
// Opcode classifier of the sequencer
// Maps an opcode to its target unit and its register-use flags

`timescale 1ns/1ps

module seq_decode (
  input  seq_pkg::seq_op_e op_i,
  input  logic             vm_i,
  output seq_pkg::decoded_t dec_o
);

  ////////////////////////////////////////////////////////////
  // Decode table
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Nothing read or written unless the table says so
    dec_o = '{unit: seq_pkg::UNIT_ALU, default: 1'b0};
    unique case (op_i)
      seq_pkg::OP_VADD,
      seq_pkg::OP_VSUB: begin
        dec_o.unit      = seq_pkg::UNIT_ALU;
        dec_o.use_vs1   = 1'b1;
        dec_o.use_vs2   = 1'b1;
        dec_o.writes_vd = 1'b1;
      end
      seq_pkg::OP_VMUL: begin
        dec_o.unit      = seq_pkg::UNIT_MUL;
        dec_o.use_vs1   = 1'b1;
        dec_o.use_vs2   = 1'b1;
        dec_o.writes_vd = 1'b1;
      end
      seq_pkg::OP_VMACC: begin
        // Accumulator is both source and destination
        dec_o.unit      = seq_pkg::UNIT_MUL;
        dec_o.use_vs1   = 1'b1;
        dec_o.use_vs2   = 1'b1;
        dec_o.reads_vd  = 1'b1;
        dec_o.writes_vd = 1'b1;
      end
      seq_pkg::OP_VLE: begin
        dec_o.unit      = seq_pkg::UNIT_LOAD;
        dec_o.writes_vd = 1'b1;
      end
      seq_pkg::OP_VSE: begin
        // Store data comes in through vs1
        dec_o.unit    = seq_pkg::UNIT_STORE;
        dec_o.use_vs1 = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: src/seq_scoreboard.sv
// Dependency tracking of the sequencer: register access lists, running table,
// ID allocation, unit occupancy and completion of finished instructions

`timescale 1ns/1ps

module seq_scoreboard #(
  parameter int unsigned UnitQueueDepth = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  seq_pkg::seq_req_t                           req_i,
  input  seq_pkg::decoded_t                           dec_i,
  input  logic                                        issue_fire_i,
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_done_i,
  output seq_pkg::vid_t                               next_id_o,
  output seq_pkg::vinsn_mask_t                        hazard_vs1_o,
  output seq_pkg::vinsn_mask_t                        hazard_vs2_o,
  output seq_pkg::vinsn_mask_t                        hazard_vm_o,
  output seq_pkg::vinsn_mask_t                        hazard_vd_o,
  output logic                                        can_issue_o,
  output logic                                        idle_o
);

  // Last instruction that touched a register
  typedef struct packed {
    seq_pkg::vid_t id;
    logic          valid;
  } vreg_access_t;

  vreg_access_t [seq_pkg::NrVRegs-1:0] read_list_d, read_list_q;
  vreg_access_t [seq_pkg::NrVRegs-1:0] write_list_d, write_list_q;

  // One row of running IDs per unit
  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] running_d, running_q;
  seq_pkg::vinsn_mask_t                        any_running_q;
  seq_pkg::vinsn_mask_t                        war_mask;

  logic [$clog2(seq_pkg::NrVInsn+1)-1:0] occupancy;
  logic                                  id_free;
  logic                                  idle_q;

  // One-hot owner of an entry, empty once the owner has completed
  function automatic seq_pkg::vinsn_mask_t owner_bit(vreg_access_t entry,
                                                     seq_pkg::vinsn_mask_t running);
    seq_pkg::vinsn_mask_t bits;
    bits           = '0;
    bits[entry.id] = entry.valid & running[entry.id];
    return bits;
  endfunction

  ////////////////////////////////////////////////////////////
  // ID allocation and occupancy
  ////////////////////////////////////////////////////////////

  always_comb begin
    any_running_q = '0;
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      any_running_q |= running_q[u];
    end
  end

  // Lowest free ID wins, scan from the top so the last hit is the lowest
  always_comb begin
    next_id_o = '0;
    id_free   = 1'b0;
    for (int i = seq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!any_running_q[i]) begin
        next_id_o = seq_pkg::vid_t'(i);
        id_free   = 1'b1;
      end
    end
  end

  // Running IDs of the target unit only
  always_comb begin
    occupancy = '0;
    for (int i = 0; i < seq_pkg::NrVInsn; i++) begin
      occupancy = occupancy + $bits(occupancy)'(running_q[dec_i.unit][i]);
    end
  end

  assign can_issue_o = id_free && (occupancy < UnitQueueDepth);

  ////////////////////////////////////////////////////////////
  // Hazards
  ////////////////////////////////////////////////////////////

  // WAR, a new write must wait for the last reader of vd
  assign war_mask = dec_i.writes_vd ? owner_bit(read_list_q[req_i.vd], any_running_q) : '0;

  // RAW on each source, plus the WAR reader on all of them
  assign hazard_vs1_o = war_mask |
    (dec_i.use_vs1 ? owner_bit(write_list_q[req_i.vs1], any_running_q) : '0);
  assign hazard_vs2_o = war_mask |
    (dec_i.use_vs2 ? owner_bit(write_list_q[req_i.vs2], any_running_q) : '0);
  assign hazard_vm_o  = war_mask |
    (!req_i.vm ? owner_bit(write_list_q[seq_pkg::MaskReg], any_running_q) : '0);

  // WAW
  assign hazard_vd_o = dec_i.writes_vd ? owner_bit(write_list_q[req_i.vd], any_running_q) : '0;

  ////////////////////////////////////////////////////////////
  // Running table and access lists
  ////////////////////////////////////////////////////////////

  always_comb begin
    running_d    = running_q;
    read_list_d  = read_list_q;
    write_list_d = write_list_q;

    // Completion
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      running_d[u] = running_q[u] & ~unit_done_i[u];
    end

    // Drop entries of finished owners before their ID comes back
    for (int r = 0; r < seq_pkg::NrVRegs; r++) begin
      read_list_d[r].valid  = read_list_q[r].valid & any_running_q[read_list_q[r].id];
      write_list_d[r].valid = write_list_q[r].valid & any_running_q[write_list_q[r].id];
    end

    if (issue_fire_i) begin
      running_d[dec_i.unit][next_id_o] = 1'b1;
      if (dec_i.writes_vd) write_list_d[req_i.vd] = '{id: next_id_o, valid: 1'b1};
      // Only the most recent reader is kept
      if (dec_i.use_vs1) read_list_d[req_i.vs1] = '{id: next_id_o, valid: 1'b1};
      if (dec_i.use_vs2) read_list_d[req_i.vs2] = '{id: next_id_o, valid: 1'b1};
      if (dec_i.reads_vd) read_list_d[req_i.vd] = '{id: next_id_o, valid: 1'b1};
      if (!req_i.vm) read_list_d[seq_pkg::MaskReg] = '{id: next_id_o, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q    <= '0;
      read_list_q  <= '0;
      write_list_q <= '0;
      idle_q       <= 1'b1;
    end else begin
      running_q    <= running_d;
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
      idle_q       <= (running_d == '0);
    end
  end

  assign idle_o = idle_q;

  // Issue stage only fires when there is an ID and unit room
  issue_needs_room: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_fire_i |-> can_issue_o
  ) else $error("issue without free ID or unit slot");

  // Units only retire what they were given
  done_only_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (unit_done_i & ~running_q) == '0
  ) else $error("done reported for an ID that is not running");

endmodule

// File: src/seq_issue.sv
// Issue stage of the sequencer
// Dispatcher handshake and the registered request toward the units

`timescale 1ns/1ps

module seq_issue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Dispatcher side
  input  seq_pkg::seq_req_t    req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // From decode and scoreboard
  input  seq_pkg::decoded_t    dec_i,
  input  seq_pkg::vid_t        next_id_i,
  input  seq_pkg::vinsn_mask_t hazard_vs1_i,
  input  seq_pkg::vinsn_mask_t hazard_vs2_i,
  input  seq_pkg::vinsn_mask_t hazard_vm_i,
  input  seq_pkg::vinsn_mask_t hazard_vd_i,
  input  logic                 can_issue_i,
  output logic                 issue_fire_o,
  // Unit side
  output seq_pkg::pe_req_t     pe_req_o,
  output logic                 pe_req_valid_o,
  input  logic                 pe_req_ready_i
);

  logic out_free;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Output slot is free when empty or being taken this cycle
  assign out_free     = !pe_req_valid_o || pe_req_ready_i;
  assign req_ready_o  = can_issue_i && out_free;
  assign issue_fire_o = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (issue_fire_o) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_req_ready_i) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Payload only loads on a transfer, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (issue_fire_o) begin
      pe_req_o <= '{
        id        : next_id_i,
        op        : req_i.op,
        unit      : dec_i.unit,
        vd        : req_i.vd,
        vs1       : req_i.vs1,
        vs2       : req_i.vs2,
        vm        : req_i.vm,
        hazard_vs1: hazard_vs1_i,
        hazard_vs2: hazard_vs2_i,
        hazard_vm : hazard_vm_i,
        hazard_vd : hazard_vd_i
      };
    end
  end

  // A stalled request is neither dropped nor changed
  pe_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o && !pe_req_ready_i |=> pe_req_valid_o && $stable(pe_req_o)
  ) else $error("pe_req_o changed while stalled");

endmodule

// File: src/vec_sequencer.sv
// Top level of the vector instruction sequencer
// Connects decode, scoreboard and issue stage

`timescale 1ns/1ps

module vec_sequencer #(
  parameter int unsigned UnitQueueDepth = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  seq_pkg::seq_req_t                           req_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  output seq_pkg::pe_req_t                            pe_req_o,
  output logic                                        pe_req_valid_o,
  input  logic                                        pe_req_ready_i,
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_done_i,
  output logic                                        idle_o
);

  seq_pkg::decoded_t    dec;
  seq_pkg::vid_t        next_id;
  seq_pkg::vinsn_mask_t hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;
  logic                 can_issue;
  logic                 issue_fire;

  seq_decode i_decode (
    .op_i (req_i.op),
    .vm_i (req_i.vm),
    .dec_o(dec)
  );

  // Depth limit per unit is set here only
  seq_scoreboard #(
    .UnitQueueDepth(UnitQueueDepth)
  ) i_scoreboard (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .dec_i       (dec),
    .issue_fire_i(issue_fire),
    .unit_done_i (unit_done_i),
    .next_id_o   (next_id),
    .hazard_vs1_o(hazard_vs1),
    .hazard_vs2_o(hazard_vs2),
    .hazard_vm_o (hazard_vm),
    .hazard_vd_o (hazard_vd),
    .can_issue_o (can_issue),
    .idle_o      (idle_o)
  );

  seq_issue i_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .dec_i         (dec),
    .next_id_i     (next_id),
    .hazard_vs1_i  (hazard_vs1),
    .hazard_vs2_i  (hazard_vs2),
    .hazard_vm_i   (hazard_vm),
    .hazard_vd_i   (hazard_vd),
    .can_issue_i   (can_issue),
    .issue_fire_o  (issue_fire),
    .pe_req_o      (pe_req_o),
    .pe_req_valid_o(pe_req_valid_o),
    .pe_req_ready_i(pe_req_ready_i)
  );

endmodule

// File: dv/seq_clk_gen.sv
// Clock and reset source of the sequencer testbench
// 4 ns clock, reset held low for the first 5 rising edges

`timescale 1ns/1ps

module seq_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HalfPeriod  = 2;
  localparam int unsigned ResetCycles = 5;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Release on a rising edge like every other input
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: dv/seq_tb.sv
// Testbench of the vector sequencer
// Runs the commands of dv/seq_tests.txt and checks each request that reaches the units

`timescale 1ns/1ps

module seq_tb;

  localparam int unsigned ClkPeriod     = 4;
  localparam int unsigned CyclesPerLine = 200;

  // One command of the test file with up to 11 hex fields
  typedef struct packed {
    logic [7:0]        cmd;
    logic [10:0][31:0] f;
  } test_cmd_t;

  logic                                        clk;
  logic                                        rst_n;
  seq_pkg::seq_req_t                           req;
  logic                                        req_valid;
  logic                                        req_ready;
  seq_pkg::pe_req_t                            pe_req;
  logic                                        pe_req_valid;
  logic                                        pe_req_ready;
  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_done;
  logic                                        idle;

  test_cmd_t        tests[$];
  seq_pkg::pe_req_t expected_q[$];
  seq_pkg::pe_req_t held_req;
  logic             held = 1'b0;
  bit               loaded = 1'b0;
  int unsigned      stall_cycles;
  int unsigned      mismatches = 0;
  int unsigned      other_errors = 0;

  seq_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  vec_sequencer #(
    .UnitQueueDepth(2)
  ) dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .pe_req_o      (pe_req),
    .pe_req_valid_o(pe_req_valid),
    .pe_req_ready_i(pe_req_ready),
    .unit_done_i   (unit_done),
    .idle_o        (idle)
  );

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    other_errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Test file
  ////////////////////////////////////////////////////////////

  // Number of hex fields after each command letter
  function automatic int field_count(input logic [7:0] c);
    case (c)
      "I": return 11;
      "B": return 6;
      "D": return 2;
      "S", "C": return 1;
      default: return 0;
    endcase
  endfunction

  task automatic load_tests();
    int          fd;
    int          ch;
    int          nargs;
    int          rc;
    logic [7:0]  c;
    logic [31:0] v;
    test_cmd_t   t;
    fd = $fopen("dv/seq_tests.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the test file dv/seq_tests.txt");
      return;
    end
    while ($fscanf(fd, " %c", c) == 1) begin
      if (c == "#") begin
        // Comment line, skip to its end
        ch = 0;
        while (ch != "\n" && ch != -1)
          ch = $fgetc(fd);
      end else begin
        t.cmd = c;
        t.f   = '0;
        nargs = field_count(c);
        if (nargs == 0) begin
          report_error("unknown command letter in the test file");
          break;
        end
        for (int i = 0; i < nargs; i++) begin
          rc = $fscanf(fd, "%h", v);
          if (rc != 1) report_error("test file ends in the middle of a command");
          t.f[i] = v;
        end
        tests.push_back(t);
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////

  // Raise valid with the request of an I or B line
  task automatic present(input test_cmd_t t);
    seq_pkg::seq_req_t r;
    r.op  = seq_pkg::seq_op_e'(t.f[0][2:0]);
    r.vd  = t.f[1][4:0];
    r.vs1 = t.f[2][4:0];
    r.vs2 = t.f[3][4:0];
    r.vm  = t.f[4][0];
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
  endtask

  task automatic issue_req(input test_cmd_t t);
    seq_pkg::pe_req_t exp;
    exp.id         = t.f[6][2:0];
    exp.op         = seq_pkg::seq_op_e'(t.f[0][2:0]);
    exp.unit       = seq_pkg::unit_e'(t.f[5][1:0]);
    exp.vd         = t.f[1][4:0];
    exp.vs1        = t.f[2][4:0];
    exp.vs2        = t.f[3][4:0];
    exp.vm         = t.f[4][0];
    exp.hazard_vs1 = t.f[7][7:0];
    exp.hazard_vs2 = t.f[8][7:0];
    exp.hazard_vm  = t.f[9][7:0];
    exp.hazard_vd  = t.f[10][7:0];
    present(t);
    @(posedge clk);
    while (!req_ready)
      @(posedge clk);
    // A new request may not slip in while the held one is blocked
    check_eq("accept while the unit side stalls", pe_req_valid && !pe_req_ready, 1'b0);
    expected_q.push_back(exp);
    req_valid <= 1'b0;
  endtask

  task automatic refuse_req(input test_cmd_t t);
    present(t);
    repeat (t.f[5]) begin
      @(posedge clk);
      check_eq("req_ready_o for a request that must wait", req_ready, 1'b0);
    end
    req_valid <= 1'b0;
  endtask

  // One-cycle done pulse on one unit
  task automatic mark_done(input logic [1:0] unit, input seq_pkg::vinsn_mask_t ids);
    @(posedge clk);
    unit_done[unit] <= ids;
    @(posedge clk);
    unit_done[unit] <= '0;
  endtask

  task automatic hold_back();
    pe_req_ready <= 1'b0;
    repeat (stall_cycles) @(posedge clk);
    pe_req_ready <= 1'b1;
  endtask

  task automatic run_cmd(input test_cmd_t t);
    case (t.cmd)
      "I": issue_req(t);
      "B": refuse_req(t);
      "D": mark_done(t.f[0][1:0], t.f[1][7:0]);
      "S": begin
        // Back-pressure runs beside the following commands
        @(posedge clk);
        stall_cycles = t.f[0];
        fork
          hold_back();
        join_none
      end
      "C": begin
        @(posedge clk);
        check_eq("idle_o", idle, t.f[0][0]);
      end
      default: report_error("unknown command");
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Unit side monitor
  ////////////////////////////////////////////////////////////

  task automatic take_req();
    seq_pkg::pe_req_t exp;
    if (expected_q.size() == 0) begin
      report_error("the units received a request that was never issued");
      return;
    end
    exp = expected_q.pop_front();
    check_eq("id", pe_req.id, exp.id);
    check_eq("unit", pe_req.unit, exp.unit);
    check_eq("op and registers", {pe_req.op, pe_req.vd, pe_req.vs1, pe_req.vs2, pe_req.vm},
             {exp.op, exp.vd, exp.vs1, exp.vs2, exp.vm});
    check_eq("hazard_vs1", pe_req.hazard_vs1, exp.hazard_vs1);
    check_eq("hazard_vs2", pe_req.hazard_vs2, exp.hazard_vs2);
    check_eq("hazard_vm", pe_req.hazard_vm, exp.hazard_vm);
    check_eq("hazard_vd", pe_req.hazard_vd, exp.hazard_vd);
  endtask

  // Requests come out in issue order and hold still while stalled
  always @(posedge clk) begin
    if (rst_n && pe_req_valid) begin
      if (held) check_eq("pe_req_o under back-pressure", pe_req, held_req);
      if (pe_req_ready) begin
        held = 1'b0;
        take_req();
      end else begin
        held     = 1'b1;
        held_req = pe_req;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    req          = '0;
    req_valid    = 1'b0;
    pe_req_ready = 1'b1;
    unit_done    = '0;
    load_tests();
    loaded = 1'b1;
    wait (rst_n);
    for (int i = 0; i < tests.size(); i++) begin
      run_cmd(tests[i]);
    end
    // Drain what is still on its way to the units
    while (expected_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((tests.size() + 1) * CyclesPerLine * ClkPeriod);
    $display("run timed out after %0d cycles", (tests.size() + 1) * CyclesPerLine);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: verilog.f
src/seq_pkg.sv
src/seq_decode.sv
src/seq_scoreboard.sv
src/seq_issue.sv
src/vec_sequencer.sv
dv/seq_clk_gen.sv
dv/seq_tb.sv

// File: dv/seq_tests.txt
# I op vd vs1 vs2 vm unit id hz_vs1 hz_vs2 hz_vm hz_vd | B op vd vs1 vs2 vm cycles
# D unit ids | S cycles | C idle | all hex, op 0 add 1 sub 2 mul 3 macc 4 le 5 se
C 1
I 4 01 00 00 1 2 0 00 00 00 00
C 0
I 0 02 01 03 1 0 1 01 00 00 00
D 2 01
I 0 09 01 03 1 0 0 00 00 00 00
D 0 03
C 1
# RAW, masked RAW, WAR and WAW
I 4 00 00 00 1 2 0 00 00 00 00
I 4 02 00 00 1 2 1 00 00 00 00
I 2 04 05 02 0 1 2 00 02 01 00
I 0 02 06 07 1 0 3 04 04 04 02
I 3 04 02 08 1 1 4 08 00 00 04
I 5 00 04 00 1 3 5 10 00 00 00
# Load unit full
B 4 0b 00 00 1 0a
I 0 0c 0d 0e 1 0 6 00 00 00 00
D 2 01
I 4 0b 00 00 1 2 0 00 00 00 00
D 1 14
D 0 48
# Back-pressure from the units
S 6
I 0 0f 10 11 1 0 2 00 00 00 00
I 2 12 0f 13 1 1 3 04 00 00 00
D 3 20
D 2 03
D 0 04
C 0
D 1 08
C 1
